//--- logic/mult_pkg.sv
package mult_pkg;

   // Operand width of the multiplier when the top level is not overridden
   parameter int default_width = 16;

   // One Booth digit per bit pair of the multiplier. The extra digit on top
   // sees the last bit pair padded with zeros, so an unsigned operand with its
   // top bit set still ends in a positive digit
   function automatic int booth_groups(input int width);
      return width / 2 + 1;
   endfunction

   // Rows that go into carry-save reduction: one per Booth digit, plus the
   // correction row that holds the negate bits and the sign constant
   function automatic int pp_rows(input int width);
      return booth_groups(width) + 1;
   endfunction

endpackage

//--- logic/booth_pkg.sv
package booth_pkg;

   // Radix-4 Booth digit, i.e. the multiple of the multiplicand that one
   // bit pair of the multiplier selects
   typedef enum logic [2:0] {
      op_zero   = 3'd0,
      op_plus1  = 3'd1,
      op_plus2  = 3'd2,
      op_minus1 = 3'd3,
      op_minus2 = 3'd4
   } booth_op_e;

   // The window is {high bit, middle bit, low bit}, where the low bit is the
   // high bit of the previous pair (zero below the first pair)
   function automatic booth_op_e encode(input logic [2:0] window);
      booth_op_e op;
      case (window)
         3'b001,
         3'b010:  op = op_plus1;
         3'b011:  op = op_plus2;
         3'b100:  op = op_minus2;
         3'b101,
         3'b110:  op = op_minus1;
         // 000 and 111 select nothing
         default: op = op_zero;
      endcase
      return op;
   endfunction

endpackage

//--- logic/booth_pp_gen.sv
`timescale 1ns/1ps

module booth_pp_gen #(
   parameter int width = mult_pkg::default_width
) (
   input  logic                                             clk,
   input  logic                                             rst_n,
   input  logic [width-1:0]                                 mx,
   input  logic [width-1:0]                                 my,
   output logic [mult_pkg::pp_rows(width)-1:0][2*width-1:0] rows
);

   localparam int groups = mult_pkg::booth_groups(width);
   localparam int rows_n = mult_pkg::pp_rows(width);

   // Each row carries only one sign bit, stored inverted above its payload.
   // Every inverted bit is worth 2^(width+1) too much, and this constant takes
   // all of that back at once. Weights at or above 2^(2*width) drop out
   function automatic logic [2*width-1:0] sign_const();
      logic [2*width-1:0] acc;
      logic [2*width-1:0] one;
      acc = '0;
      one = 1;
      for (int j = 0; j < groups; j++) begin
         acc = acc - (one << (width + 1 + 2 * j));
      end
      return acc;
   endfunction

   localparam logic [2*width-1:0] ext_const = sign_const();

   // Signed multiple of my that a digit stands for. A code outside the five
   // digits maps to a value that no window can reach
   function automatic int digit_value(input booth_pkg::booth_op_e op);
      int v;
      case (op)
         booth_pkg::op_zero:   v = 0;
         booth_pkg::op_plus1:  v = 1;
         booth_pkg::op_plus2:  v = 2;
         booth_pkg::op_minus1: v = -1;
         booth_pkg::op_minus2: v = -2;
         default:              v = 3;
      endcase
      return v;
   endfunction

   logic [width+2:0]               mx_ext;
   booth_pkg::booth_op_e           ops [groups];
   logic [groups-1:0]              neg;
   logic [rows_n-1:0][2*width-1:0] rows_d;

   // Zero below bit 0 for the first window and two zeros on top for the
   // extra digit
   assign mx_ext = {2'b00, mx, 1'b0};

   always_comb begin
      logic [width:0]     sel;
      logic [2*width-1:0] row;
      // The last row is the correction row. Its negate bits go in below
      rows_d[rows_n-1] = ext_const;
      for (int j = 0; j < groups; j++) begin
         ops[j] = booth_pkg::encode(mx_ext[2*j+2 -: 3]);
         neg[j] = (ops[j] == booth_pkg::op_minus1) || (ops[j] == booth_pkg::op_minus2);
         case (ops[j])
            booth_pkg::op_plus1,
            booth_pkg::op_minus1: sel = {1'b0, my};
            booth_pkg::op_plus2,
            booth_pkg::op_minus2: sel = {my, 1'b0};
            default:              sel = '0;
         endcase
         // Ones complement here, the +1 of the twos complement sits in the
         // correction row at this row's least significant position
         row = '0;
         row[width+1:0] = {~neg[j], sel ^ {(width + 1){neg[j]}}};
         rows_d[j] = row << (2 * j);
         rows_d[rows_n-1][2*j] = neg[j];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rows <= '0;
      end else begin
         rows <= rows_d;
      end
   end

   // The digit of a window {h, m, l} is worth m + l - 2h. A wrong or illegal
   // opcode would silently drop or distort a term of the product
   for (genvar j = 0; j < groups; j++) begin : g_op_check
      a_digit_value: assert property (@(posedge clk) disable iff (!rst_n)
         digit_value(ops[j]) ==
            int'(mx_ext[2*j+1]) + int'(mx_ext[2*j]) - 2 * int'(mx_ext[2*j+2]));
   end

endmodule

//--- logic/csa_tree.sv
`timescale 1ns/1ps

module csa_tree #(
   parameter int width = mult_pkg::default_width
) (
   input  logic                                             clk,
   input  logic                                             rst_n,
   input  logic [mult_pkg::pp_rows(width)-1:0][2*width-1:0] rows,
   output logic [2*width-1:0]                               sum_row,
   output logic [2*width-1:0]                               carry_row
);

   localparam int rows_n = mult_pkg::pp_rows(width);

   // Number of Wallace levels: every full group of three rows becomes two
   function automatic int tree_levels(input int n);
      int count;
      int k;
      count = n;
      k = 0;
      while (count > 2) begin
         count = count - count / 3;
         k++;
      end
      return k;
   endfunction

   localparam int levels = tree_levels(rows_n);

   function automatic logic [2*width-1:0] row_total(
      input logic [rows_n-1:0][2*width-1:0] r
   );
      logic [2*width-1:0] acc;
      acc = '0;
      for (int i = 0; i < rows_n; i++) begin
         acc = acc + r[i];
      end
      return acc;
   endfunction

   logic [2*width-1:0] level_rows [rows_n];
   logic [2*width-1:0] next_rows  [rows_n];

   // Only the first count entries of level_rows are live at each level.
   // The row counts depend on width alone, so the loops unroll into a fixed
   // tree of 3:2 compressors
   always_comb begin
      int count;
      int n_full;
      for (int r = 0; r < rows_n; r++) begin
         level_rows[r] = rows[r];
      end
      count = rows_n;
      for (int l = 0; l < levels; l++) begin
         n_full = count / 3;
         next_rows = '{default: '0};
         for (int g = 0; g < rows_n / 3; g++) begin
            if (g < n_full) begin
               next_rows[2*g] = level_rows[3*g] ^ level_rows[3*g+1] ^ level_rows[3*g+2];
               next_rows[2*g+1] = ((level_rows[3*g] & level_rows[3*g+1]) |
                                   (level_rows[3*g] & level_rows[3*g+2]) |
                                   (level_rows[3*g+1] & level_rows[3*g+2])) << 1;
            end
         end
         // Leftover rows of an incomplete group go on to the next level as they are
         for (int r = 0; r < rows_n; r++) begin
            if (r >= 3 * n_full && r < count) begin
               next_rows[r - n_full] = level_rows[r];
            end
         end
         count = count - n_full;
         level_rows = next_rows;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sum_row   <= '0;
         carry_row <= '0;
      end else begin
         sum_row   <= level_rows[0];
         carry_row <= level_rows[1];
      end
   end

   // The two rows must keep the value of all input rows modulo 2^(2*width),
   // the shifted-out carries included
   a_sum_kept: assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) |-> (sum_row + carry_row) == $past(row_total(rows)));

endmodule

//--- logic/prefix_adder.sv
`timescale 1ns/1ps

module prefix_adder #(
   parameter int width = mult_pkg::default_width
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [2*width-1:0]   sum_row,
   input  logic [2*width-1:0]   carry_row,
   output logic [2*width-1:0]   product
);

   localparam int levels = $clog2(2 * width);

   logic [2*width-1:0] half;
   logic [2*width-1:0] gen;
   logic [2*width-1:0] prop;
   logic [2*width-1:0] result;

   assign half = sum_row ^ carry_row;

   // Kogge-Stone tree. After level l, gen[i] tells whether bits i down to
   // i-2^(l+1)+1 produce a carry, and prop[i] whether they pass one through
   always_comb begin
      logic [2*width-1:0] gen_prev;
      logic [2*width-1:0] prop_prev;
      gen  = sum_row & carry_row;
      prop = half;
      gen_prev  = gen;
      prop_prev = prop;
      for (int l = 0; l < levels; l++) begin
         gen_prev  = gen;
         prop_prev = prop;
         for (int i = 1 << l; i < 2 * width; i++) begin
            gen[i]  = gen_prev[i] | (prop_prev[i] & gen_prev[i - (1 << l)]);
            prop[i] = prop_prev[i] & prop_prev[i - (1 << l)];
         end
      end
   end

   // gen[i] is now the carry out of bit i, so bit i+1 takes it in.
   // Carry-in is zero and the carry out of the top bit is dropped
   assign result = half ^ {gen[2*width-2:0], 1'b0};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         product <= '0;
      end else begin
         product <= result;
      end
   end

   // An unknown here means an unknown got through both earlier stages
   a_product_known: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(product));

endmodule

//--- logic/booth_mult.sv
`timescale 1ns/1ps

// Unsigned radix-4 Booth multiplier in three pipeline stages. One operand pair
// enters on every edge, and the product leaves the output register after
// passing the row, carry-save and adder registers
module booth_mult #(
   parameter int width = mult_pkg::default_width
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [width-1:0]     mx,
   input  logic [width-1:0]     my,
   output logic [2*width-1:0]   product
);

   logic [mult_pkg::pp_rows(width)-1:0][2*width-1:0] rows;
   logic [2*width-1:0]                               sum_row;
   logic [2*width-1:0]                               carry_row;

   booth_pp_gen #(
      .width(width)
   ) pp_gen_i (
      .clk   (clk),
      .rst_n (rst_n),
      .mx    (mx),
      .my    (my),
      .rows  (rows)
   );

   csa_tree #(
      .width(width)
   ) csa_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .rows      (rows),
      .sum_row   (sum_row),
      .carry_row (carry_row)
   );

   prefix_adder #(
      .width(width)
   ) adder_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .sum_row   (sum_row),
      .carry_row (carry_row),
      .product   (product)
   );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
   parameter int period_ns    = 40,
   parameter int reset_cycles = 3
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(period_ns / 2) clk = ~clk;
   end

   // Release on a falling edge so that no rising edge sees it change
   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

//--- test/booth_mult_tb.sv
`timescale 1ns/1ps

module booth_mult_tb;

   localparam int width = 16;
   localparam int throughput_pairs = 300;

   // Operand patterns that repeat the same bit pairs across the multiplier
   localparam logic [width-1:0] patterns [7] = '{
      16'haaaa, 16'h5555, 16'hcccc, 16'h3333, 16'h7fff, 16'h9999, 16'h6666
   };

   logic               clk;
   logic               por_n;
   logic               stream_rst_n;
   logic               rst_n;
   logic [width-1:0]   mx;
   logic [width-1:0]   my;
   logic [2*width-1:0] product;

   integer seed = 32'h8b98_d772;
   string  test_name;
   logic   feeding;
   int     check_count = 0;
   int     in_flight = 0;

   // One entry per pipeline register, oldest first
   logic [2*width-1:0] exp_q  [$];
   string              name_q [$];
   logic               live_q [$];

   assign rst_n = por_n & stream_rst_n;

   tb_clock #(
      .period_ns    (40),
      .reset_cycles (3)
   ) clock_i (
      .clk   (clk),
      .rst_n (por_n)
   );

   booth_mult #(
      .width(width)
   ) dut_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .mx      (mx),
      .my      (my),
      .product (product)
   );

   // Shift and add over the bits of a
   function automatic logic [2*width-1:0] ref_product(
      input logic [width-1:0] a,
      input logic [width-1:0] b
   );
      logic [2*width-1:0] acc;
      logic [2*width-1:0] addend;
      acc = '0;
      addend = {{width{1'b0}}, b};
      for (int i = 0; i < width; i++) begin
         if (a[i]) begin
            acc = acc + addend;
         end
         addend = addend << 1;
      end
      return acc;
   endfunction

   function automatic logic [width-1:0] rand_operand();
      int r;
      r = $random(seed);
      return r[width-1:0];
   endfunction

   task automatic report_failure(input string reason);
      $display("%s", reason);
      $display("Test FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(
      input string              name,
      input logic [2*width-1:0] expected,
      input logic [2*width-1:0] actual
   );
      if (actual !== expected) begin
         report_failure($sformatf("error %s expected %h actual %h", name, expected, actual));
      end
   endtask

   task automatic drive_pair(
      input string            name,
      input logic [width-1:0] a,
      input logic [width-1:0] b
   );
      @(negedge clk);
      test_name = name;
      mx = a;
      my = b;
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (por_n !== 1'b1) begin
         @(posedge clk);
         n++;
         if (n > 20) begin
            report_failure("timeout while waiting for the reset to be released");
         end
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (in_flight != 0) begin
         @(posedge clk);
         n++;
         if (n > 10) begin
            report_failure("timeout while waiting for the pipeline to drain");
         end
      end
   endtask

   // The model mirrors the three pipeline registers. The output is read at
   // the rising edge, before the DUT updates it, so the oldest entry is due
   always @(posedge clk) begin
      if (!rst_n) begin
         exp_q.delete();
         name_q.delete();
         live_q.delete();
         in_flight = 0;
         repeat (3) begin
            exp_q.push_back('0);
            name_q.push_back("reset");
            live_q.push_back(1'b0);
         end
      end
      check_value(name_q[0], exp_q[0], product);
      if (live_q[0]) begin
         check_count++;
      end
      if (rst_n) begin
         if (live_q[0]) begin
            in_flight--;
         end
         void'(exp_q.pop_front());
         void'(name_q.pop_front());
         void'(live_q.pop_front());
         exp_q.push_back(ref_product(mx, my));
         name_q.push_back(test_name);
         live_q.push_back(feeding);
         if (feeding) begin
            in_flight++;
         end
      end
   end

   initial begin
      mx = '0;
      my = '0;
      stream_rst_n = 1'b1;
      feeding = 1'b0;
      test_name = "reset output";

      check_value("reference self-test", 32'hfffe0001, ref_product(16'hffff, 16'hffff));

      wait_reset_release();
      repeat (3) drive_pair("reset output", '0, '0);
      feeding = 1'b1;

      drive_pair("corner zero", 16'h0000, 16'h1234);
      drive_pair("corner zero", 16'hffff, 16'h0000);
      drive_pair("corner one", 16'h0001, 16'h0001);
      drive_pair("corner max", 16'hffff, 16'hffff);
      drive_pair("corner top bit", 16'h8000, 16'h8000);
      drive_pair("corner max by one", 16'hffff, 16'h0001);
      drive_pair("corner max by one", 16'h0001, 16'hffff);

      // mx is the Booth-encoded operand, so each pattern goes there first
      foreach (patterns[p]) begin
         for (int i = 0; i < 6; i++) begin
            drive_pair("digit opcodes", patterns[p], rand_operand());
            drive_pair("digit opcodes", rand_operand(), patterns[p]);
         end
      end

      for (int i = 0; i < throughput_pairs; i++) begin
         drive_pair("full throughput", rand_operand(), rand_operand());
      end

      // Reset is held for three falling edges while operands keep coming
      for (int i = 0; i < 44; i++) begin
         drive_pair("reset mid-stream", rand_operand(), rand_operand());
         stream_rst_n = !(i >= 20 && i < 23);
      end

      @(negedge clk);
      feeding = 1'b0;
      mx = '0;
      my = '0;
      wait_drain();

      if (check_count > throughput_pairs) begin
         $display("Test OK");
         $finish;
      end else begin
         report_failure("fewer products were checked than were driven");
      end
   end

endmodule

//--- list.f
logic/mult_pkg.sv
logic/booth_pkg.sv
logic/booth_pp_gen.sv
logic/csa_tree.sv
logic/prefix_adder.sv
logic/booth_mult.sv
test/tb_clock.sv
test/booth_mult_tb.sv

//--- Makefile
TOP = booth_mult_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)
	@out=$$(./obj_dir/$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
